//--- timer_pkg.sv
// ----------------------------------------------------------------------
// register map and fixed widths of the timer peripheral
// all widths are fixed by the map, addresses are word addresses
// ----------------------------------------------------------------------
`default_nettype none

package timer_pkg;

  // ----------------------------------------------------------------------
  // widths
  // ----------------------------------------------------------------------
  localparam int timer_width = 32;
  localparam int addr_width  = 8;
  localparam int data_width  = 32;

  // ----------------------------------------------------------------------
  // register addresses
  // ----------------------------------------------------------------------
  localparam logic [addr_width-1:0] addr_name       = 8'h00;
  localparam logic [addr_width-1:0] addr_ctrl       = 8'h08;
  localparam logic [addr_width-1:0] addr_status     = 8'h09;
  localparam logic [addr_width-1:0] addr_prescaler  = 8'h0a;
  localparam logic [addr_width-1:0] addr_timer      = 8'h0b;
  localparam logic [addr_width-1:0] addr_curr_timer = 8'h0c;
  localparam logic [addr_width-1:0] addr_irq_en     = 8'h0d;

  // control bits, write-only and self-clearing
  localparam int ctrl_start_bit = 0;
  localparam int ctrl_stop_bit  = 1;

  // status bits
  localparam int status_running_bit = 0;
  localparam int status_reached_bit = 1;

  // ascii "time"
  localparam logic [data_width-1:0] core_name = 32'h74696d65;

  // core control machine states
  localparam logic ctrl_idle    = 1'b0;
  localparam logic ctrl_running = 1'b1;

endpackage

`default_nettype wire

//--- timer_core.sv
// ----------------------------------------------------------------------
// prescaler and counter run only between start and stop
// prescaler_init of zero never wraps, timer_init of zero never reaches
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module timer_core
  import timer_pkg::*;
(
  input  wire                    clk,
  input  wire                    prescaler_rst,
  input  wire  [timer_width-1:0] prescaler_init,
  input  wire  [timer_width-1:0] timer_init,
  input  wire                    start,
  input  wire                    stop,
  output logic [timer_width-1:0] curr_timer,
  output logic                   reached,
  output logic                   running
);

  // ----------------------------------------------------------------------
  // state
  // ----------------------------------------------------------------------
  logic                   core_ctrl_reg;
  logic                   core_ctrl_new;
  logic                   reached_reg;
  logic                   reached_new;
  logic [timer_width-1:0] prescaler_reg;
  logic [timer_width-1:0] timer_reg;

  // counter controls from the control machine
  logic prescaler_clr;
  logic prescaler_inc;
  logic timer_clr;
  logic timer_inc;

  // wrap points
  logic prescaler_last;
  logic timer_last;

  assign curr_timer = timer_reg;
  assign reached    = reached_reg;
  // running is the registered machine state itself
  assign running    = (core_ctrl_reg == ctrl_running);

  // prescaler about to wrap, timer one below target
  assign prescaler_last = (prescaler_reg == (prescaler_init - 1'b1));
  assign timer_last     = (timer_reg == (timer_init - 1'b1));

  // ----------------------------------------------------------------------
  // registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (prescaler_rst) begin
      core_ctrl_reg <= ctrl_idle;
      reached_reg   <= 1'b0;
      prescaler_reg <= '0;
      timer_reg     <= '0;
    end else begin
      core_ctrl_reg <= core_ctrl_new;
      reached_reg   <= reached_new;

      // clear wins over increment
      if (prescaler_clr) begin
        prescaler_reg <= '0;
      end else if (prescaler_inc) begin
        prescaler_reg <= prescaler_reg + 1'b1;
      end

      if (timer_clr) begin
        timer_reg <= '0;
      end else if (timer_inc) begin
        timer_reg <= timer_reg + 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // control machine
  // ----------------------------------------------------------------------
  always_comb begin
    // hold by default
    core_ctrl_new = core_ctrl_reg;
    reached_new   = reached_reg;
    prescaler_clr = 1'b0;
    prescaler_inc = 1'b0;
    timer_clr     = 1'b0;
    timer_inc     = 1'b0;

    case (core_ctrl_reg)
      ctrl_idle: begin
        // counters restart from zero on every start
        if (start) begin
          core_ctrl_new = ctrl_running;
          prescaler_clr = 1'b1;
          timer_clr     = 1'b1;
        end
      end

      ctrl_running: begin
        if (stop) begin
          // timer value frozen, reached dropped
          core_ctrl_new = ctrl_idle;
          reached_new   = 1'b0;
        end else if (prescaler_last) begin
          // one prescaled tick
          prescaler_clr = 1'b1;
          timer_inc     = 1'b1;
          if (timer_last) begin
            reached_new = 1'b1;
          end
        end else begin
          prescaler_inc = 1'b1;
        end
      end

      default: begin
        core_ctrl_new = ctrl_idle;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- timer_regs.sv
// ----------------------------------------------------------------------
// plain chip-select register bus, no wait states
// start and stop reach the core two edges after the write edge
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module timer_regs
  import timer_pkg::*;
(
  input  wire                    clk,
  input  wire                    prescaler_rst,
  input  wire                    cs,
  input  wire                    we,
  input  wire  [addr_width-1:0]  address,
  input  wire  [data_width-1:0]  write_data,
  input  wire  [timer_width-1:0] curr_timer,
  input  wire                    running,
  input  wire                    reached_flag,
  output logic [data_width-1:0]  read_data,
  output logic [timer_width-1:0] prescaler_init,
  output logic [timer_width-1:0] timer_init,
  output logic                   start,
  output logic                   stop,
  output logic                   irq_en,
  output logic                   reached_clear
);

  // ----------------------------------------------------------------------
  // decode
  // ----------------------------------------------------------------------
  logic                  wr_en;
  logic                  rd_en;
  logic                  ctrl_wr;
  logic                  status_wr;
  logic                  start_pend;
  logic                  stop_pend;
  logic [data_width-1:0] rd_mux;

  assign wr_en     = cs & we;
  assign rd_en     = cs & ~we;
  assign ctrl_wr   = wr_en & (address == addr_ctrl);
  assign status_wr = wr_en & (address == addr_status);

  // ----------------------------------------------------------------------
  // configuration registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (prescaler_rst) begin
      prescaler_init <= '0;
      timer_init     <= '0;
      irq_en         <= 1'b0;
    end else if (wr_en) begin
      case (address)
        // values locked while the core runs
        addr_prescaler: begin
          if (!running) begin
            prescaler_init <= write_data;
          end
        end
        addr_timer: begin
          if (!running) begin
            timer_init <= write_data;
          end
        end
        addr_irq_en: begin
          irq_en <= write_data[0];
        end
        // unmapped or read-only
        default: begin
        end
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // control and status strobes
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (prescaler_rst) begin
      start_pend    <= 1'b0;
      stop_pend     <= 1'b0;
      start         <= 1'b0;
      stop          <= 1'b0;
      reached_clear <= 1'b0;
    end else begin
      // captured at the write edge
      start_pend    <= ctrl_wr & write_data[ctrl_start_bit];
      stop_pend     <= ctrl_wr & write_data[ctrl_stop_bit];
      // one cycle later to the core
      start         <= start_pend;
      stop          <= stop_pend;
      // write one to clear
      reached_clear <= status_wr & write_data[status_reached_bit];
    end
  end

  // ----------------------------------------------------------------------
  // read mux
  // ----------------------------------------------------------------------
  always_comb begin
    rd_mux = '0;
    case (address)
      addr_name: begin
        rd_mux = core_name;
      end
      addr_status: begin
        rd_mux[status_running_bit] = running;
        rd_mux[status_reached_bit] = reached_flag;
      end
      addr_prescaler: begin
        rd_mux = prescaler_init;
      end
      addr_timer: begin
        rd_mux = timer_init;
      end
      addr_curr_timer: begin
        rd_mux = curr_timer;
      end
      addr_irq_en: begin
        rd_mux[0] = irq_en;
      end
      // ctrl is write-only, others unmapped
      default: begin
        rd_mux = '0;
      end
    endcase
  end

  // held until the next read
  always_ff @(posedge clk) begin
    if (prescaler_rst) begin
      read_data <= '0;
    end else if (rd_en) begin
      read_data <= rd_mux;
    end
  end

endmodule

`default_nettype wire

//--- timer_event.sv
// ----------------------------------------------------------------------
// sticky reached flag set on the rising edge of reached only
// a set and a clear in the same cycle leave the flag set
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module timer_event (
  input  wire  clk,
  input  wire  prescaler_rst,
  input  wire  reached,
  input  wire  irq_en,
  input  wire  reached_clear,
  output logic reached_flag,
  output logic irq
);

  // ----------------------------------------------------------------------
  // edge detect
  // ----------------------------------------------------------------------
  logic reached_d;
  logic reached_edge;
  logic flag_next;

  // reached was low last cycle, high now
  assign reached_edge = reached & ~reached_d;

  // ----------------------------------------------------------------------
  // flag next value
  // ----------------------------------------------------------------------
  always_comb begin
    flag_next = reached_flag;
    if (reached_edge) begin
      flag_next = 1'b1;
    end else if (reached_clear) begin
      flag_next = 1'b0;
    end
  end

  // ----------------------------------------------------------------------
  // registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (prescaler_rst) begin
      reached_d    <= 1'b0;
      reached_flag <= 1'b0;
      irq          <= 1'b0;
    end else begin
      reached_d    <= reached;
      reached_flag <= flag_next;
      // from the next flag value, so irq rises with the flag
      irq          <= flag_next & irq_en;
    end
  end

endmodule

`default_nettype wire

//--- timer.sv
// ----------------------------------------------------------------------
// timer peripheral top, single clock domain
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module timer
  import timer_pkg::*;
(
  input  wire                   clk,
  input  wire                   prescaler_rst,
  input  wire                   cs,
  input  wire                   we,
  input  wire  [addr_width-1:0] address,
  input  wire  [data_width-1:0] write_data,
  output logic [data_width-1:0] read_data,
  output logic                  irq
);

  // ----------------------------------------------------------------------
  // internal nets
  // ----------------------------------------------------------------------
  // configuration
  logic [timer_width-1:0] prescaler_init;
  logic [timer_width-1:0] timer_init;
  logic                   irq_en;
  // strobes
  logic                   start;
  logic                   stop;
  logic                   reached_clear;
  // core status
  logic [timer_width-1:0] curr_timer;
  logic                   reached;
  logic                   running;
  logic                   reached_flag;

  timer_regs timer_regs_inst (
    .clk            (clk),
    .prescaler_rst  (prescaler_rst),
    .cs             (cs),
    .we             (we),
    .address        (address),
    .write_data     (write_data),
    .curr_timer     (curr_timer),
    .running        (running),
    .reached_flag   (reached_flag),
    .read_data      (read_data),
    .prescaler_init (prescaler_init),
    .timer_init     (timer_init),
    .start          (start),
    .stop           (stop),
    .irq_en         (irq_en),
    .reached_clear  (reached_clear)
  );

  timer_core timer_core_inst (
    .clk            (clk),
    .prescaler_rst  (prescaler_rst),
    .prescaler_init (prescaler_init),
    .timer_init     (timer_init),
    .start          (start),
    .stop           (stop),
    .curr_timer     (curr_timer),
    .reached        (reached),
    .running        (running)
  );

  timer_event timer_event_inst (
    .clk           (clk),
    .prescaler_rst (prescaler_rst),
    .reached       (reached),
    .irq_en        (irq_en),
    .reached_clear (reached_clear),
    .reached_flag  (reached_flag),
    .irq           (irq)
  );

endmodule

`default_nettype wire

//--- tb_timer_checker.sv
// ----------------------------------------------------------------------
// compares read_data and irq on the rising edge where a strobe is high
// values seen are the ones settled after the previous edge
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_timer_checker
  import timer_pkg::*;
(
  input  wire                  clk,
  input  wire                  read_check,
  input  wire                  irq_check,
  input  wire [data_width-1:0] expected_data,
  input  wire [data_width-1:0] read_data,
  input  wire                  expected_irq,
  input  wire                  irq,
  output logic [31:0]          check_count,
  output logic [31:0]          data_errors,
  output logic [31:0]          irq_errors
);

  initial begin
    $timeformat(-9, 0, " ns", 0);
    check_count = 0;
    data_errors = 0;
    irq_errors  = 0;
  end

  // ----------------------------------------------------------------------
  // compare
  // ----------------------------------------------------------------------
  always @(posedge clk) begin
    // read data held since the read edge
    if (read_check) begin
      check_count <= check_count + 1;
      if (read_data !== expected_data) begin
        $display("error at %0t: read_data expected %h, actual %h",
                 $time, expected_data, read_data);
        data_errors <= data_errors + 1;
      end
    end
    // irq level
    if (irq_check) begin
      check_count <= check_count + 1;
      if (irq !== expected_irq) begin
        $display("error at %0t: irq expected %b, actual %b",
                 $time, expected_irq, irq);
        irq_errors <= irq_errors + 1;
      end
    end
  end

endmodule

`default_nettype wire

//--- tb_timer.sv
// ----------------------------------------------------------------------
// trace-driven testbench, rows of timer_trace.txt run in file order
// bus inputs change on the falling edge only, one bus operation at a time
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_timer
  import timer_pkg::*;
();

  // row kinds and trace capacity
  localparam int max_rows   = 128;
  localparam int kind_write = 0;
  localparam int kind_read  = 1;
  localparam int kind_wait  = 2;
  localparam int kind_irq   = 3;

  // ----------------------------------------------------------------------
  // dut and checker signals
  // ----------------------------------------------------------------------
  logic                  clk;
  logic                  prescaler_rst;
  logic                  cs;
  logic                  we;
  logic [addr_width-1:0] address;
  logic [data_width-1:0] write_data;
  logic [data_width-1:0] read_data;
  logic                  irq;
  logic                  read_check;
  logic                  irq_check;
  logic [data_width-1:0] expected_data;
  logic                  expected_irq;
  logic [31:0]           check_count;
  logic [31:0]           data_errors;
  logic [31:0]           irq_errors;

  // loaded trace
  int          row_kind  [0:max_rows-1];
  logic [31:0] row_addr  [0:max_rows-1];
  logic [31:0] row_value [0:max_rows-1];
  int          row_count;
  int          trace_checks;
  int          cycle_limit;
  int          cycle_count = 0;
  logic        limit_ready = 1'b0;
  logic        load_ok;

  timer timer_inst (
    .clk           (clk),
    .prescaler_rst (prescaler_rst),
    .cs            (cs),
    .we            (we),
    .address       (address),
    .write_data    (write_data),
    .read_data     (read_data),
    .irq           (irq)
  );

  tb_timer_checker checker_inst (
    .clk           (clk),
    .read_check    (read_check),
    .irq_check     (irq_check),
    .expected_data (expected_data),
    .read_data     (read_data),
    .expected_irq  (expected_irq),
    .irq           (irq),
    .check_count   (check_count),
    .data_errors   (data_errors),
    .irq_errors    (irq_errors)
  );

  // 8 ns period
  always #4 clk = ~clk;

  // ----------------------------------------------------------------------
  // trace loading, also sizes the run limit
  // ----------------------------------------------------------------------
  task automatic load_trace(output logic ok);
    int          fd;
    int          n;
    int          kind;
    int          line_no;
    string       line;
    string       cmd;
    logic [31:0] a;
    logic [31:0] v;
    ok           = 1'b1;
    row_count    = 0;
    trace_checks = 0;
    cycle_limit  = 50;
    line_no      = 0;
    fd = $fopen("timer_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open the trace file timer_trace.txt");
      ok = 1'b0;
    end else begin
      while (ok && $fgets(line, fd) > 0) begin
        line_no++;
        n = $sscanf(line, "%s", cmd);
        // blank and comment lines
        if (n < 1 || cmd.getc(0) == "#") begin
          continue;
        end
        a = '0;
        v = '0;
        // bus rows carry hex fields, the others one decimal field
        if (cmd == "write" || cmd == "read") begin
          n = $sscanf(line, "%s %h %h", cmd, a, v) - 1;
        end else begin
          n = $sscanf(line, "%s %d", cmd, v);
        end
        if (cmd == "write") begin
          kind = kind_write;
        end else if (cmd == "read") begin
          kind = kind_read;
        end else if (cmd == "wait") begin
          kind = kind_wait;
        end else if (cmd == "expect_irq") begin
          kind = kind_irq;
        end else begin
          kind = -1;
        end
        if (kind < 0 || n != 2 || row_count == max_rows) begin
          $display("trace line %0d is malformed or the trace is too long", line_no);
          ok = 1'b0;
        end else begin
          row_kind[row_count]  = kind;
          row_addr[row_count]  = a;
          row_value[row_count] = v;
          row_count++;
          if (kind == kind_wait) begin
            cycle_limit += v;
          end else begin
            cycle_limit += 4;
          end
          if (kind == kind_read || kind == kind_irq) begin
            trace_checks++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // ----------------------------------------------------------------------
  // bus operations, each starts and ends on a falling edge
  // ----------------------------------------------------------------------
  task automatic bus_write(input logic [31:0] a, input logic [31:0] d);
    cs         = 1'b1;
    we         = 1'b1;
    address    = a[addr_width-1:0];
    write_data = d;
    @(negedge clk);
    cs = 1'b0;
    we = 1'b0;
  endtask

  task automatic bus_read(input logic [31:0] a, input logic [31:0] expected);
    cs      = 1'b1;
    we      = 1'b0;
    address = a[addr_width-1:0];
    @(negedge clk);
    // read_data registered now, checker samples on the next edge
    cs            = 1'b0;
    read_check    = 1'b1;
    expected_data = expected;
    @(negedge clk);
    read_check = 1'b0;
  endtask

  task automatic irq_level_check(input logic level);
    irq_check    = 1'b1;
    expected_irq = level;
    @(negedge clk);
    irq_check = 1'b0;
  endtask

  // run limit, counts once the trace is loaded
  always @(posedge clk) begin
    if (limit_ready) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
        $display("timeout after %0d cycles, the trace did not finish", cycle_count);
        $display("Regression failed");
        $finish;
      end
    end
  end

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    clk           = 1'b0;
    prescaler_rst = 1'b1;
    cs            = 1'b0;
    we            = 1'b0;
    address       = '0;
    write_data    = '0;
    read_check    = 1'b0;
    irq_check     = 1'b0;
    expected_data = '0;
    expected_irq  = 1'b0;
    load_trace(load_ok);
    if (!load_ok) begin
      $display("Regression failed");
      $finish;
    end else begin
      limit_ready = 1'b1;
      repeat (5) @(posedge clk);
      @(negedge clk);
      prescaler_rst = 1'b0;
      for (int i = 0; i < row_count; i++) begin
        if (row_kind[i] == kind_write) begin
          bus_write(row_addr[i], row_value[i]);
        end else if (row_kind[i] == kind_read) begin
          bus_read(row_addr[i], row_value[i]);
        end else if (row_kind[i] == kind_wait) begin
          repeat (row_value[i]) @(negedge clk);
        end else begin
          irq_level_check(row_value[i][0]);
        end
      end
      @(negedge clk);
      $display("checks %0d of %0d, read_data errors %0d, irq errors %0d",
               check_count, trace_checks, data_errors, irq_errors);
      if (check_count != trace_checks) begin
        $display("checker saw a different number of checks than the trace holds");
      end
      if (data_errors == 0 && irq_errors == 0 && check_count == trace_checks) begin
        $display("Regression passed");
      end else begin
        $display("Regression failed");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- timer_trace.txt
# columns: command, then hex address and hex value for write and read (value is expected),
# or a decimal cycle count for wait and a level for expect_irq
# after reset
read 00 74696d65
read 09 0
read 0c 0
read 0d 0
expect_irq 0
# prescaler 3, target 5, irq enabled, start
write 0a 3
write 0b 5
write 0d 1
read 0a 3
read 0b 5
write 08 1
wait 3
read 09 1
read 0c 1
wait 4
read 0c 3
# reached flag and irq, timer past target
wait 6
read 09 3
expect_irq 1
read 0c 6
# clear the flag, no new edge
write 09 2
wait 2
read 09 1
expect_irq 0
wait 8
read 09 1
# locked values, stop and frozen count
write 0a 7
write 0b 9
read 0a 3
read 0b 5
write 08 2
wait 3
read 09 0
read 0c f
wait 5
read 0c f
# restart with irq disabled
write 0d 0
write 08 1
wait 20
read 09 3
expect_irq 0
read 0d 0
write 08 2
wait 3
read 09 2
read 0c 8
read 08 0
read 05 0

//--- files.f
timer_pkg.sv
timer_core.sv
timer_regs.sv
timer_event.sv
timer.sv
tb_timer_checker.sv
tb_timer.sv
